//--- Makefile
TOP := uartCore_tb

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps --top-module $(TOP) -Mdir obj_dir -f project.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qF "=== PASS ==="

clean:
	rm -rf obj_dir

.PHONY: sim clean

//--- baudGen.sv
// ==========================================================
// phase accumulator, 16x oversampling tick on carry out
// zero increment stops the ticks, phase kept across changes
// ==========================================================
`timescale 1ns/100ps
`default_nettype none

`include "uart_params.svh"

module baudGen import uartPkg::*; (
	input  logic clk,
	input  logic rstN,
	input  incrT incr,
	output logic tick
);

	incrT acc;                          // phase
	logic [`UART_CNT_BITS:0] sum;       // extra bit holds the carry

	assign sum = {1'b0, acc} + {1'b0, incr};

	// tick is high the cycle after the add wraps
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			acc  <= '0;
			tick <= 1'b0;
		end else begin
			acc  <= sum[`UART_CNT_BITS-1:0];
			tick <= sum[`UART_CNT_BITS];
		end
	end

endmodule

`default_nettype wire

//--- baudLUT.sv
// ==========================================================
// baud select to phase increment, 100 MHz clock assumed
// select 0 stops the baud clock, 24..31 give 19200 baud
// ==========================================================
`timescale 1ns/100ps
`default_nettype none

module baudLUT import uartPkg::*; (
	input  baudSelT baudSel,
	output incrT    incr
);

	// incr = baud * 16 * 2^32 / 100e6
	always_comb begin
		case (baudSel)
		5'd0:    incr = 32'd0;            // clock stopped
		5'd1:    incr = 32'd34360;        // 50
		5'd2:    incr = 32'd51540;        // 75
		5'd3:    incr = 32'd75591;        // 110
		5'd4:    incr = 32'd92428;        // 134.5
		5'd5:    incr = 32'd103079;       // 150
		5'd6:    incr = 32'd206158;       // 300
		5'd7:    incr = 32'd412317;       // 600
		5'd8:    incr = 32'd824634;       // 1200
		5'd9:    incr = 32'd1236951;      // 1800
		5'd10:   incr = 32'd1649267;      // 2400
		5'd11:   incr = 32'd2473901;      // 3600
		5'd12:   incr = 32'd3298535;      // 4800
		5'd13:   incr = 32'd4947802;      // 7200
		5'd14:   incr = 32'd6597070;      // 9600
		5'd15:   incr = 32'd13194140;     // 19200
		5'd16:   incr = 32'd26388279;     // 38400
		5'd17:   incr = 32'd39582419;     // 57600
		5'd18:   incr = 32'd79164837;     // 115200
		5'd19:   incr = 32'd158329674;    // 230400
		5'd20:   incr = 32'd316659349;    // 460800
		5'd21:   incr = 32'd633318698;    // 921600
		5'd22:   incr = 32'd1266637395;   // 1843200
		5'd23:   incr = 32'd2533274790;   // 3686400
		// unused selects fall back to a safe common rate
		default: incr = 32'd13194140;     // 19200
		endcase
	end

endmodule

`default_nettype wire

//--- project.f
+incdir+.
uartPkg.sv
baudLUT.sv
baudGen.sv
uartTx.sv
uartRx.sv
uartCore.sv
tb_clkGen.sv
uartCore_props.sv
uartCore_tb.sv

//--- tb_clkGen.sv
// ==========================================================
// testbench clock, 40 ns period (25 MHz)
// reset held low for the first 2 rising edges
// ==========================================================
`timescale 1ns/100ps
`default_nettype none

module tb_clkGen (
	output logic clk,
	output logic rstN
);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		rstN = 1'b0;
		repeat (2) @(posedge clk);
		#2 rstN = 1'b1;                 // release off the edge
	end

endmodule

`default_nettype wire

//--- uartCore.sv
// ==========================================================
// serial port top, 8N1, no FIFOs and no back-pressure
// baud select 0 stops both directions
// ==========================================================
`timescale 1ns/100ps
`default_nettype none

module uartCore import uartPkg::*; (
	input  logic    clk,
	input  logic    rstN,
	input  baudSelT baudSel,
	input  logic    txStart,
	input  dataT    txData,
	output logic    txBusy,
	output logic    txd,
	input  logic    rxd,
	output dataT    rxData,
	output logic    rxValid,
	output logic    rxFrameErr
);

	incrT incr;                         // phase increment for the selected rate
	logic tick;                         // 16x bit rate

	baudLUT u_lut (
		.baudSel (baudSel),
		.incr    (incr)
	);

	baudGen u_gen (
		.clk  (clk),
		.rstN (rstN),
		.incr (incr),
		.tick (tick)
	);

	// both directions share one tick
	uartTx u_tx (
		.clk     (clk),
		.rstN    (rstN),
		.tick    (tick),
		.txStart (txStart),
		.txData  (txData),
		.txBusy  (txBusy),
		.txd     (txd)
	);

	uartRx u_rx (
		.clk        (clk),
		.rstN       (rstN),
		.tick       (tick),
		.rxd        (rxd),          // synchronized inside
		.rxData     (rxData),
		.rxValid    (rxValid),
		.rxFrameErr (rxFrameErr)
	);

endmodule

`default_nettype wire

//--- uartCore_props.sv
// ==========================================================
// bound checks on the serial port outputs
// failCount is read by the testbench at the end
// ==========================================================
`timescale 1ns/100ps
`default_nettype none

module uartCore_props (
	input logic clk,
	input logic rstN,
	input logic txBusy,
	input logic txd,
	input logic rxValid,
	input logic rxFrameErr
);

	int failCount = 0;

	// idle transmitter keeps the line high
	idleLineHigh: assert property (@(posedge clk) disable iff (!rstN) !txBusy |-> txd)
		else begin
			failCount++;
			$error("txd low while txBusy is low");
		end

	rxValidPulse: assert property (@(posedge clk) disable iff (!rstN) rxValid |=> !rxValid)
		else begin
			failCount++;
			$error("rxValid high for two cycles");
		end

	// error flag only rides on the data strobe
	frameErrWithValid: assert property (@(posedge clk) disable iff (!rstN) rxFrameErr |-> rxValid)
		else begin
			failCount++;
			$error("rxFrameErr high without rxValid");
		end

endmodule

bind uartCore uartCore_props u_props (
	.clk        (clk),
	.rstN       (rstN),
	.txBusy     (txBusy),
	.txd        (txd),
	.rxValid    (rxValid),
	.rxFrameErr (rxFrameErr)
);

`default_nettype wire

//--- uartCore_tb.sv
// ==========================================================
// directed tests for uartCore, clock runs at 25 MHz
// bit lengths follow the 100 MHz table rule, so all rates are 1/4
// ==========================================================
`timescale 1ns/100ps
`default_nettype none

`include "uart_params.svh"

module uartCore_tb import uartPkg::*; ();

	logic clk, rstN;
	baudSelT baudSel;
	logic txStart;
	dataT txData;
	logic txBusy, txd, rxd, rxValid, rxFrameErr;
	dataT rxData;
	logic loopback;                     // 1: rxd follows txd
	logic rxdDrv;                       // injected line level
	int errors, failedTests;
	int rxCount = 0;                    // rxValid pulses seen
	dataT lastData;
	logic lastErr;
	logic [31:0] lcgState;

	assign rxd = loopback ? txd : rxdDrv;

	tb_clkGen u_clk (.clk(clk), .rstN(rstN));

	uartCore u_dut (
		.clk        (clk),
		.rstN       (rstN),
		.baudSel    (baudSel),
		.txStart    (txStart),
		.txData     (txData),
		.txBusy     (txBusy),
		.txd        (txd),
		.rxd        (rxd),
		.rxData     (rxData),
		.rxValid    (rxValid),
		.rxFrameErr (rxFrameErr)
	);

	// receive monitor, outputs are stable at the falling edge
	always @(negedge clk) begin
		if (rxValid) begin
			rxCount = rxCount + 1;
			lastData = rxData;
			lastErr = rxFrameErr;
		end
	end

	// ============================================================
	// helpers
	// ============================================================
	function automatic logic [31:0] lcgNext(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// nominal rate for the selects exercised here
	function automatic real baudFor(input int sel);
		case (sel)
		0:       return 0.0;            // stopped
		14:      return 9600.0;
		21:      return 921600.0;
		22:      return 1843200.0;
		23:      return 3686400.0;
		default: return 19200.0;        // 15 and the 24..31 fallback
		endcase
	endfunction

	// incr = baud * 16 * 2^32 / 100 MHz, bit = 16 * 2^32 / incr clocks
	function automatic real bitClocks(input int sel);
		real incr;
		incr = baudFor(sel) * real'(`UART_OVERSAMPLE) * 4294967296.0 / 100.0e6;
		if (incr == 0.0)
			return 0.0;
		return real'(`UART_OVERSAMPLE) * 4294967296.0 / incr;
	endfunction

	function automatic int clocksFor(input int sel, input real bits);
		return $rtoi(bits * bitClocks(sel) + 0.5);
	endfunction

	// n clocks, ends 2 ns after an edge
	task automatic step(input int n);
		repeat (n) begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic sendByte(input dataT b);
		txData = b;
		txStart = 1'b1;
		step(1);
		txStart = 1'b0;
	endtask

	task automatic waitTxBusy(input logic level, input int limit, output logic ok);
		int n;
		n = 0;
		while (txBusy !== level && n < limit) begin
			step(1);
			n++;
		end
		ok = (txBusy === level);
		if (!ok) begin
			$display("Timeout at %0t: txBusy not %b after %0d clocks", $time, level, limit);
			errors++;
		end
	endtask

	// n returns clocks spent waiting
	task automatic waitTxd(input logic level, input int limit, output logic ok, output int n);
		n = 0;
		while (txd !== level && n < limit) begin
			step(1);
			n++;
		end
		ok = (txd === level);
		if (!ok) begin
			$display("Timeout at %0t: txd not %b after %0d clocks", $time, level, limit);
			errors++;
		end
	endtask

	task automatic waitRx(input int startCount, input int limit, output logic ok);
		int n;
		n = 0;
		while (rxCount == startCount && n < limit) begin
			step(1);
			n++;
		end
		ok = (rxCount != startCount);
		if (!ok) begin
			$display("Timeout at %0t: no rxValid within %0d clocks", $time, limit);
			errors++;
		end
	endtask

	// stop bit cut to 3/4 so the receiver restart sees a high line at half bit
	task automatic driveFrame(input int sel, input dataT b, input logic stopBit);
		logic [9:0] bits;
		int n, target;
		bits = {stopBit, b, 1'b0};      // start bit goes first
		n = 0;
		for (int k = 0; k < 10; k++) begin
			rxdDrv = bits[k];
			target = clocksFor(sel, (k < 9) ? k + 1.0 : 9.75);
			step(target - n);
			n = target;
		end
		rxdDrv = 1'b1;
	endtask

	task automatic report(input string name, input int startErr);
		if (errors == startErr) begin
			$display("test %s: passed", name);
		end else begin
			$display("test %s: failed, %0d errors", name, errors - startErr);
			failedTests++;
		end
	endtask

	// ============================================================
	// tests
	// ============================================================
	task automatic loopbackTest();
		int startErr, cnt;
		dataT b;
		logic ok;
		startErr = errors;
		loopback = 1'b1;
		baudSel = 5'd22;
		for (int i = 0; i < 8; i++) begin
			lcgState = lcgNext(lcgState);
			b = lcgState[23:16];
			waitTxBusy(1'b0, clocksFor(22, 12.0), ok);
			cnt = rxCount;
			sendByte(b);
			waitRx(cnt, clocksFor(22, 12.0), ok);
			if (ok && (lastData !== b || lastErr !== 1'b0)) begin
				$display("Error at %0t: sent %h, got %h, frame error %b",
					$time, b, lastData, lastErr);
				errors++;
			end
		end
		waitTxBusy(1'b0, clocksFor(22, 12.0), ok);
		report("1 loopback data", startErr);
	endtask

	task automatic frameShapeTest();
		int startErr, n, target;
		dataT b;
		logic ok;
		logic [9:0] want, got;
		startErr = errors;
		baudSel = 5'd21;
		lcgState = lcgNext(lcgState);
		b = lcgState[23:16];
		want = {1'b1, b, 1'b0};
		got = '0;
		sendByte(b);
		waitTxd(1'b0, clocksFor(21, 2.0), ok, n);
		if (ok) begin
			n = 0;                      // fall was at the last edge
			for (int k = 0; k < 10; k++) begin
				target = clocksFor(21, k + 0.5);   // mid bit
				step(target - n);
				n = target;
				got[k] = txd;
			end
			if (got !== want) begin
				$display("Error at %0t: frame bits %b, expected %b", $time, got, want);
				errors++;
			end
			// half a stop bit left plus one bit of slack
			waitTxBusy(1'b0, clocksFor(21, 1.5), ok);
		end
		report("2 frame shape", startErr);
	endtask

	task automatic stoppedClockTest();
		int startErr, cnt;
		dataT b;
		logic ok, stayedHigh;
		startErr = errors;
		baudSel = 5'd0;
		step(4);                        // drain a tick in flight
		lcgState = lcgNext(lcgState);
		b = lcgState[23:16];
		cnt = rxCount;
		sendByte(b);
		if (txBusy !== 1'b1) begin
			$display("Error at %0t: txBusy low after txStart", $time);
			errors++;
		end
		stayedHigh = 1'b1;
		for (int i = 0; i < 2000; i++) begin
			if (txd !== 1'b1)
				stayedHigh = 1'b0;
			step(1);
		end
		if (!stayedHigh) begin
			$display("Error at %0t: txd moved with the baud clock stopped", $time);
			errors++;
		end
		baudSel = 5'd22;
		waitRx(cnt, clocksFor(22, 12.0), ok);
		if (ok && (lastData !== b || lastErr !== 1'b0)) begin
			$display("Error at %0t: sent %h, got %h, frame error %b",
				$time, b, lastData, lastErr);
			errors++;
		end
		waitTxBusy(1'b0, clocksFor(22, 4.0), ok);
		report("3 stopped clock", startErr);
	endtask

	task automatic errorTest();
		int startErr, cnt;
		dataT b;
		logic ok;
		startErr = errors;
		baudSel = 5'd22;
		loopback = 1'b0;
		rxdDrv = 1'b1;
		step(clocksFor(22, 2.0));
		// stop bit low
		lcgState = lcgNext(lcgState);
		b = lcgState[23:16];
		cnt = rxCount;
		driveFrame(22, b, 1'b0);
		waitRx(cnt, clocksFor(22, 4.0), ok);
		if (ok && (lastErr !== 1'b1 || lastData !== b)) begin
			$display("Error at %0t: injected %h, got %h, frame error %b",
				$time, b, lastData, lastErr);
			errors++;
		end
		step(clocksFor(22, 2.0));
		// glitch under a quarter bit
		cnt = rxCount;
		rxdDrv = 1'b0;
		step(clocksFor(22, 0.125));
		rxdDrv = 1'b1;
		step(clocksFor(22, 20.0));      // two frame times
		if (rxCount != cnt) begin
			$display("Error at %0t: glitch was taken as a frame", $time);
			errors++;
		end
		// second strobe while busy
		loopback = 1'b1;
		lcgState = lcgNext(lcgState);
		b = lcgState[23:16];
		cnt = rxCount;
		sendByte(b);
		step(clocksFor(22, 3.0));
		if (txBusy !== 1'b1) begin
			$display("Error at %0t: txBusy low in mid frame", $time);
			errors++;
		end
		sendByte(~b);                   // must be dropped
		waitTxBusy(1'b0, clocksFor(22, 12.0), ok);
		step(clocksFor(22, 20.0));
		if (rxCount != cnt + 1 || lastData !== b) begin
			$display("Error at %0t: %0d bytes arrived, last %h, expected one byte %h",
				$time, rxCount - cnt, lastData, b);
			errors++;
		end
		report("4 framing error and busy drop", startErr);
	endtask

	task automatic defaultEntryTest();
		int startErr, n;
		logic ok;
		real want, tickLen;
		startErr = errors;
		baudSel = 5'd31;
		step(4);
		sendByte(8'hA5);                // LSB 1 ends the start bit
		waitTxd(1'b0, clocksFor(15, 2.0), ok, n);
		if (ok) begin
			waitTxd(1'b1, clocksFor(15, 2.0), ok, n);
			want = bitClocks(15);
			tickLen = want / real'(`UART_OVERSAMPLE);
			if (ok && (real'(n) < want - tickLen || real'(n) > want + tickLen)) begin
				$display("Error at %0t: start bit %0d clocks, expected %0.1f",
					$time, n, want);
				errors++;
			end
			waitTxBusy(1'b0, clocksFor(15, 11.0), ok);
		end
		report("5 default entry", startErr);
	endtask

	// ============================================================
	// run
	// ============================================================
	initial begin
		int total;
		baudSel = 5'd22;
		txStart = 1'b0;
		txData = '0;
		rxdDrv = 1'b1;
		loopback = 1'b1;
		errors = 0;
		failedTests = 0;
		lcgState = 32'h6d8b3edf;
		step(4);                        // past reset
		loopbackTest();
		frameShapeTest();
		stoppedClockTest();
		errorTest();
		defaultEntryTest();
		total = errors + u_dut.u_props.failCount;
		$display("tests run 5, failed %0d, errors %0d", failedTests, total);
		if (total == 0 && failedTests == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

//--- uartPkg.sv
// ==========================================================
// shared types for the serial port
// ==========================================================
`default_nettype none

`include "uart_params.svh"

package uartPkg;

	typedef logic [4:0] baudSelT;                   // table index
	typedef logic [`UART_CNT_BITS-1:0] incrT;       // phase increment
	typedef logic [`UART_DATA_BITS-1:0] dataT;      // one data byte

	// transmitter FSM
	typedef enum logic [2:0] {txIdle, txWaitTick, txStart, txData, txStop} txStateT;

	// receiver FSM
	typedef enum logic [1:0] {rxIdle, rxStart, rxData, rxStop} rxStateT;

endpackage

`default_nettype wire

//--- uartRx.sv
// ==========================================================
// 8N1 receiver, samples each bit in the middle
// unread data is overwritten by the next frame
// ==========================================================
`timescale 1ns/100ps
`default_nettype none

`include "uart_params.svh"

module uartRx import uartPkg::*; (
	input  logic clk,
	input  logic rstN,
	input  logic tick,
	input  logic rxd,
	output dataT rxData,
	output logic rxValid,
	output logic rxFrameErr
);

	rxStateT state;                     // literals scoped, rxData is also a port
	logic rxdMeta, rxdSync;             // two-flop synchronizer
	logic [3:0] tickCnt;
	logic [2:0] bitCnt;
	dataT shiftReg;
	logic halfBit, fullBit;

	assign halfBit = tick && (tickCnt == 4'(`UART_OVERSAMPLE / 2 - 1));
	assign fullBit = tick && (tickCnt == 4'(`UART_OVERSAMPLE - 1));

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			rxdMeta <= 1'b1;
			rxdSync <= 1'b1;
		end else begin
			rxdMeta <= rxd;
			rxdSync <= rxdMeta;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state      <= uartPkg::rxIdle;
			tickCnt    <= '0;
			bitCnt     <= '0;
			rxValid    <= 1'b0;
			rxFrameErr <= 1'b0;
		end else begin
			rxValid    <= 1'b0;         // single-cycle strobes
			rxFrameErr <= 1'b0;
			if (tick)
				tickCnt <= tickCnt + 4'd1;
			case (state)
			uartPkg::rxIdle:
				if (!rxdSync) begin     // falling edge seen
					state   <= uartPkg::rxStart;
					tickCnt <= '0;
				end
			uartPkg::rxStart:
				if (halfBit) begin
					tickCnt <= '0;      // sample points now at mid-bit
					bitCnt  <= '0;
					// line back high, glitch shorter than half a bit
					state   <= rxdSync ? uartPkg::rxIdle : uartPkg::rxData;
				end
			uartPkg::rxData:
				if (fullBit) begin
					if (bitCnt == 3'(`UART_DATA_BITS - 1))
						state <= uartPkg::rxStop;
					else
						bitCnt <= bitCnt + 3'd1;
				end
			uartPkg::rxStop:
				if (fullBit) begin
					state      <= uartPkg::rxIdle;
					rxValid    <= 1'b1;
					rxFrameErr <= !rxdSync;  // stop bit must be high
				end
			default: state <= uartPkg::rxIdle;
			endcase
		end
	end

	// data path, LSB arrives first
	always_ff @(posedge clk) begin
		if (state == uartPkg::rxData && fullBit)
			shiftReg <= {rxdSync, shiftReg[`UART_DATA_BITS-1:1]};
		if (state == uartPkg::rxStop && fullBit)
			rxData <= shiftReg;         // held until the next frame ends
	end

endmodule

`default_nettype wire

//--- uartTx.sv
// ==========================================================
// 8N1 transmitter, one byte per txStart strobe
// strobes while txBusy is high are dropped
// ==========================================================
`timescale 1ns/100ps
`default_nettype none

`include "uart_params.svh"

module uartTx import uartPkg::*; (
	input  logic clk,
	input  logic rstN,
	input  logic tick,
	input  logic txStart,
	input  dataT txData,
	output logic txBusy,
	output logic txd
);

	// state literals are scoped, ports share two of the names
	txStateT state;
	logic [3:0] tickCnt;                // ticks within a bit
	logic [2:0] bitCnt;                 // data bit index
	dataT shiftReg;
	logic bitEnd;

	assign bitEnd = tick && (tickCnt == 4'(`UART_OVERSAMPLE - 1));
	assign txBusy = (state != uartPkg::txIdle);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state   <= uartPkg::txIdle;
			tickCnt <= '0;
			bitCnt  <= '0;
			txd     <= 1'b1;            // line idles high
		end else begin
			if (tick)
				tickCnt <= tickCnt + 4'd1;
			case (state)
			uartPkg::txIdle:
				if (txStart)
					state <= uartPkg::txWaitTick;
			uartPkg::txWaitTick:
				if (tick) begin         // align start bit to the tick grid
					state   <= uartPkg::txStart;
					tickCnt <= '0;
					txd     <= 1'b0;
				end
			uartPkg::txStart:
				if (bitEnd) begin
					state  <= uartPkg::txData;
					bitCnt <= '0;
					txd    <= shiftReg[0];  // LSB first
				end
			uartPkg::txData:
				if (bitEnd) begin
					if (bitCnt == 3'(`UART_DATA_BITS - 1)) begin
						state <= uartPkg::txStop;
						txd   <= 1'b1;
					end else begin
						bitCnt <= bitCnt + 3'd1;
						txd    <= shiftReg[1];  // next bit before the shift lands
					end
				end
			uartPkg::txStop:
				if (bitEnd)
					state <= uartPkg::txIdle;
			default: state <= uartPkg::txIdle;
			endcase
		end
	end

	// byte latch and shifter
	always_ff @(posedge clk) begin
		if (state == uartPkg::txIdle && txStart)
			shiftReg <= txData;
		else if (state == uartPkg::txData && bitEnd)
			shiftReg <= shiftReg >> 1;
	end

endmodule

`default_nettype wire

//--- uart_params.svh
// ==========================================================
// sizing macros for the serial port
// baud table values are only valid for a 32-bit counter
// ==========================================================
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// phase accumulator and increment width
`define UART_CNT_BITS 32

// data bits per frame, no parity, one stop bit
`define UART_DATA_BITS 8

// ticks per bit
`define UART_OVERSAMPLE 16

`endif
